/* include/apu_settings.svh */
`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// bus geometry
`define APU_XLEN 32
`define APU_ADDR_BITS 16

// clk_i cycles per apu tick
`define APU_CLK_DIV 3

// linear mixer weights
// pulse term is (p1 + p2) * weight
`define APU_PULSE_WEIGHT 8
// tnd term is (3 * tri + 2 * noise) * weight
`define APU_TND_WEIGHT 4

// lfsr start value, must be nonzero
`define APU_NOISE_SEED 15'h0001

`endif

/* verilog/apu_bus_pkg.sv */
`include "apu_settings.svh"

package apu_bus_pkg;

  typedef logic [`APU_XLEN-1:0] bus_data_t;
  typedef logic [`APU_ADDR_BITS-3:0] bus_addr_t;
  typedef logic [7:0] reg_byte_t;
  typedef logic [4:0] reg_index_t;

  typedef struct packed {
    logic [1:0]  duty;
    logic [3:0]  volume;
    logic [10:0] timer;
  } pulse_regs_t;

  typedef struct packed {
    logic [10:0] timer;
  } tri_regs_t;

  typedef struct packed {
    logic [3:0] volume;
    logic       mode;
    logic [3:0] period;
  } noise_regs_t;

  // enable bits as in register 21: noise, triangle, pulse2, pulse1
  typedef struct packed {
    pulse_regs_t pulse1;
    pulse_regs_t pulse2;
    tri_regs_t   triangle;
    noise_regs_t noise;
    logic [3:0]  enable;
  } apu_regs_t;

endpackage

/* verilog/apu_audio_pkg.sv */
package apu_audio_pkg;

  // per-channel output level
  typedef logic [3:0] level_t;

  // pulse and triangle period counters
  typedef logic [10:0] timer11_t;

  // noise periods reach 4068
  typedef logic [11:0] timer12_t;

  // mixed output
  typedef logic [15:0] sample_t;

  typedef enum logic [1:0] {
    bus_idle   = 2'b00,
    bus_decode = 2'b01,
    bus_done   = 2'b10
  } bus_state_t;

endpackage

/* verilog/apu_bus_ctrl.sv */
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_bus_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  apu_bus_pkg::bus_addr_t adr_i,
  input  logic [3:0]             sel_i,
  input  apu_bus_pkg::bus_data_t dat_i,
  output apu_bus_pkg::bus_data_t dat_o,
  output logic                   ack_o,
  output apu_bus_pkg::apu_regs_t regs_o,
  output logic                   apu_tick_o,
  output logic                   cpu_tick_o
);
  import apu_bus_pkg::*;
  import apu_audio_pkg::*;

  localparam int num_regs = 22;
  localparam int div_w = $clog2(`APU_CLK_DIV);

  bus_state_t state_q;
  logic [1:0] section_q;
  reg_index_t index_q;
  logic [1:0] lane;
  reg_byte_t  regs_q [num_regs];
  logic       hit;
  logic [div_w-1:0] div_cnt_q;

  always_comb begin
    case (sel_i)
      4'b0010: lane = 2'd1;
      4'b0100: lane = 2'd2;
      4'b1000: lane = 2'd3;
      default: lane = 2'd0;
    endcase
  end

  // only section 00 is backed by registers
  assign hit = (section_q == 2'b00) && (index_q < reg_index_t'(num_regs));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= bus_idle;
      ack_o <= 1'b0;
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      case (state_q)
        bus_idle: begin
          if (stb_i && cyc_i) begin
            section_q <= adr_i[12:11];
            index_q <= {adr_i[2:0], lane};
            state_q <= bus_decode;
          end
        end
        bus_decode: begin
          if (we_i && hit) begin
            regs_q[index_q] <= dat_i[7:0];
          end
          if (!we_i) begin
            dat_o <= hit ? bus_data_t'(regs_q[index_q]) : '0;
          end
          ack_o <= 1'b1;
          state_q <= bus_done;
        end
        default: begin
          ack_o <= 1'b0;
          state_q <= bus_idle;
        end
      endcase
    end
  end

  always_comb begin
    regs_o.pulse1.duty = regs_q[0][7:6];
    regs_o.pulse1.volume = regs_q[0][3:0];
    regs_o.pulse1.timer = {regs_q[3][2:0], regs_q[2]};
    regs_o.pulse2.duty = regs_q[4][7:6];
    regs_o.pulse2.volume = regs_q[4][3:0];
    regs_o.pulse2.timer = {regs_q[7][2:0], regs_q[6]};
    regs_o.triangle.timer = {regs_q[11][2:0], regs_q[10]};
    regs_o.noise.volume = regs_q[12][3:0];
    regs_o.noise.mode = regs_q[14][7];
    regs_o.noise.period = regs_q[14][3:0];
    regs_o.enable = regs_q[21][3:0];
  end

  // tick timebase
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      div_cnt_q <= '0;
      apu_tick_o <= 1'b0;
      cpu_tick_o <= 1'b0;
    end else begin
      cpu_tick_o <= ~cpu_tick_o;
      apu_tick_o <= (div_cnt_q == div_w'(`APU_CLK_DIV - 1));
      if (div_cnt_q == div_w'(`APU_CLK_DIV - 1)) begin
        div_cnt_q <= '0;
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o);

endmodule

/* verilog/apu_pulse.sv */
`timescale 1ns/1ps

module apu_pulse (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    tick_i,
  input  logic                    enable_i,
  input  logic [1:0]              duty_i,
  input  apu_audio_pkg::level_t   volume_i,
  input  apu_audio_pkg::timer11_t timer_i,
  output apu_audio_pkg::level_t   level_o
);
  import apu_audio_pkg::*;

  timer11_t   count_q;
  logic [2:0] step_q;
  level_t     level_q;
  logic [7:0] pattern;

  // 12.5, 25, 50 and inverted 25 percent
  function automatic logic [7:0] duty_pattern(input logic [1:0] duty);
    case (duty)
      2'd0: return 8'b1000_0000;
      2'd1: return 8'b1100_0000;
      2'd2: return 8'b1111_0000;
      default: return 8'b0011_1111;
    endcase
  endfunction

  assign pattern = duty_pattern(duty_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      step_q <= '0;
      level_q <= '0;
    end else if (tick_i) begin
      if (!enable_i) begin
        level_q <= '0;
      end else if (count_q == '0) begin
        count_q <= timer_i;
        step_q <= step_q - 3'd1;
        level_q <= pattern[step_q] ? volume_i : '0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign level_o = level_q;

endmodule

/* verilog/apu_noise.sv */
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_noise (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  tick_i,
  input  logic                  enable_i,
  input  logic                  mode_i,
  input  logic [3:0]            period_i,
  input  apu_audio_pkg::level_t volume_i,
  output apu_audio_pkg::level_t level_o
);
  import apu_audio_pkg::*;

  timer12_t    count_q;
  logic [14:0] lfsr_q;
  logic        feedback;
  level_t      level_q;

  // ntsc noise periods
  function automatic timer12_t noise_period(input logic [3:0] idx);
    case (idx)
      4'd0: return 12'd4;
      4'd1: return 12'd8;
      4'd2: return 12'd16;
      4'd3: return 12'd32;
      4'd4: return 12'd64;
      4'd5: return 12'd96;
      4'd6: return 12'd128;
      4'd7: return 12'd160;
      4'd8: return 12'd202;
      4'd9: return 12'd254;
      4'd10: return 12'd380;
      4'd11: return 12'd508;
      4'd12: return 12'd762;
      4'd13: return 12'd1016;
      4'd14: return 12'd2034;
      default: return 12'd4068;
    endcase
  endfunction

  // short mode taps bit 6
  assign feedback = lfsr_q[0] ^ (mode_i ? lfsr_q[6] : lfsr_q[1]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      lfsr_q <= `APU_NOISE_SEED;
      level_q <= '0;
    end else if (tick_i) begin
      if (!enable_i) begin
        lfsr_q <= `APU_NOISE_SEED;
        level_q <= '0;
      end else begin
        level_q <= lfsr_q[0] ? volume_i : '0;
        if (count_q == '0) begin
          count_q <= noise_period(period_i);
          lfsr_q <= {feedback, lfsr_q[14:1]};
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  assign level_o = level_q;

  lfsr_nonzero: assert property (@(posedge clk_i) disable iff (rst_i) lfsr_q != '0);

endmodule

/* verilog/apu_triangle.sv */
`timescale 1ns/1ps

module apu_triangle (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    tick_i,
  input  logic                    enable_i,
  input  apu_audio_pkg::timer11_t timer_i,
  output apu_audio_pkg::level_t   level_o
);
  import apu_audio_pkg::*;

  timer11_t   count_q;
  logic [4:0] step_q;
  level_t     level_q;

  // falls 15..0 over the first half, rises 0..15 over the second
  function automatic level_t tri_value(input logic [4:0] step);
    if (step[4]) begin
      return step[3:0];
    end
    return ~step[3:0];
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      step_q <= '0;
      level_q <= '0;
    end else if (tick_i && enable_i) begin
      // disabled channel keeps its last level
      if (count_q == '0) begin
        count_q <= timer_i;
        step_q <= step_q + 5'd1;
        level_q <= tri_value(step_q);
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign level_o = level_q;

endmodule

/* verilog/apu_mixer.sv */
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_mixer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  apu_audio_pkg::level_t  pulse1_i,
  input  apu_audio_pkg::level_t  pulse2_i,
  input  apu_audio_pkg::level_t  triangle_i,
  input  apu_audio_pkg::level_t  noise_i,
  output apu_audio_pkg::sample_t audio_o
);
  import apu_audio_pkg::*;

  // two full pulses and a full triangle plus noise
  localparam int max_sample = 30 * `APU_PULSE_WEIGHT + 75 * `APU_TND_WEIGHT;

  sample_t pulse_term;
  sample_t tnd_index;
  sample_t tnd_term;

  assign pulse_term = (sample_t'(pulse1_i) + sample_t'(pulse2_i))
                      * sample_t'(`APU_PULSE_WEIGHT);
  assign tnd_index = sample_t'(triangle_i) * 16'd3 + sample_t'(noise_i) * 16'd2;
  assign tnd_term = tnd_index * sample_t'(`APU_TND_WEIGHT);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      audio_o <= '0;
    end else begin
      audio_o <= pulse_term + tnd_term;
    end
  end

  sample_in_range: assert property (
    @(posedge clk_i) disable iff (rst_i) audio_o <= sample_t'(max_sample)
  );

endmodule

/* verilog/apu_top.sv */
`timescale 1ns/1ps

module apu_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  apu_bus_pkg::bus_addr_t adr_i,
  input  logic [3:0]             sel_i,
  input  apu_bus_pkg::bus_data_t dat_i,
  output apu_bus_pkg::bus_data_t dat_o,
  output logic                   ack_o,
  output apu_audio_pkg::sample_t audio_o
);
  import apu_bus_pkg::*;
  import apu_audio_pkg::*;

  apu_regs_t regs;
  logic      apu_tick;
  logic      cpu_tick;
  level_t    pulse1_level;
  level_t    pulse2_level;
  level_t    noise_level;
  level_t    tri_level;

  apu_bus_ctrl u_bus_ctrl (
    .clk_i(clk_i), .rst_i(rst_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .sel_i(sel_i),
    .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o),
    .regs_o(regs), .apu_tick_o(apu_tick), .cpu_tick_o(cpu_tick)
  );

  apu_pulse u_pulse1 (
    .clk_i(clk_i), .rst_i(rst_i), .tick_i(apu_tick), .enable_i(regs.enable[0]),
    .duty_i(regs.pulse1.duty), .volume_i(regs.pulse1.volume),
    .timer_i(regs.pulse1.timer), .level_o(pulse1_level)
  );

  apu_pulse u_pulse2 (
    .clk_i(clk_i), .rst_i(rst_i), .tick_i(apu_tick), .enable_i(regs.enable[1]),
    .duty_i(regs.pulse2.duty), .volume_i(regs.pulse2.volume),
    .timer_i(regs.pulse2.timer), .level_o(pulse2_level)
  );

  // triangle runs off the faster cpu tick
  apu_triangle u_triangle (
    .clk_i(clk_i), .rst_i(rst_i), .tick_i(cpu_tick), .enable_i(regs.enable[2]),
    .timer_i(regs.triangle.timer), .level_o(tri_level)
  );

  apu_noise u_noise (
    .clk_i(clk_i), .rst_i(rst_i), .tick_i(apu_tick), .enable_i(regs.enable[3]),
    .mode_i(regs.noise.mode), .period_i(regs.noise.period),
    .volume_i(regs.noise.volume), .level_o(noise_level)
  );

  apu_mixer u_mixer (
    .clk_i(clk_i), .rst_i(rst_i),
    .pulse1_i(pulse1_level), .pulse2_i(pulse2_level),
    .triangle_i(tri_level), .noise_i(noise_level),
    .audio_o(audio_o)
  );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 40,
  parameter int reset_cycles = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // release lands just after an edge, like the other inputs
  initial begin
    rst_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

/* testbench/apu_tb.sv */
`timescale 1ns/1ps
`include "apu_settings.svh"

module apu_tb;
  import apu_bus_pkg::*;
  import apu_audio_pkg::*;

  localparam int reset_cycles = 8;
  localparam int drive_delay = 2;
  localparam int ack_limit = 8;
  // worst case cycles one bus record can take
  localparam int bus_cost = 12;

  typedef struct packed {
    logic [7:0]  kind;
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] settle;
    logic [31:0] len;
    logic [31:0] weight;
    logic [31:0] lo;
    logic [31:0] step;
    logic [31:0] count;
    logic [31:0] req_a;
    logic [31:0] req_b;
  } record_t;

  logic      clk;
  logic      rst;
  logic      cyc;
  logic      stb;
  logic      we;
  bus_addr_t adr;
  logic [3:0] sel;
  bus_data_t dat_w;
  bus_data_t dat_r;
  logic      ack;
  sample_t   audio;
  record_t   records[$];
  int        budget_cycles = 0;
  integer    seed = 38119;

  tb_clock #(.period_ns(40), .reset_cycles(reset_cycles)) u_clock (
    .clk_o(clk),
    .rst_o(rst)
  );

  apu_top DUT (
    .clk_i(clk), .rst_i(rst),
    .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .sel_i(sel),
    .dat_i(dat_w), .dat_o(dat_r), .ack_o(ack),
    .audio_o(audio)
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
    end
  endtask

  task automatic load_records();
    int fd;
    int n;
    int total;
    string line;
    byte k;
    int v0, v1, v2, v3, v4, v5, v6, v7;
    record_t rec;
    total = reset_cycles;
    fd = $fopen("testbench/apu_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_error("could not open testbench/apu_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      rec = '0;
      if (line[0] == "O") begin
        n = $sscanf(line, "%c %d %d %d %d %d %d %d %d", k, v0, v1, v2, v3, v4, v5, v6, v7);
        if (n != 9) begin
          stop_with_error($sformatf("observe record has %0d fields instead of 9", n));
        end
        rec.settle = v0;
        rec.len = v1;
        rec.weight = v2;
        rec.lo = v3;
        rec.step = v4;
        rec.count = v5;
        rec.req_a = v6;
        rec.req_b = v7;
        total += v0 + v1;
      end else if (line[0] == "W" || line[0] == "R") begin
        n = $sscanf(line, "%c %h %h %h", k, v0, v1, v2);
        if (n != 4) begin
          stop_with_error($sformatf("bus record has %0d fields instead of 4", n));
        end
        rec.addr = v0;
        rec.sel = v1[3:0];
        rec.data = v2;
        total += bus_cost;
      end else begin
        stop_with_error({"unknown record kind in stimulus line: ", line});
      end
      rec.kind = line[0];
      records.push_back(rec);
    end
    $fclose(fd);
    budget_cycles = 2 * total + 100;
  endtask

  // request driven, sampled at the next edge, ack seen by the master two edges later
  task automatic bus_access(input logic write, input record_t rec);
    int waited;
    int idle;
    @(posedge clk);
    #drive_delay;
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = bus_addr_t'(rec.addr);
    sel = rec.sel;
    dat_w = write ? bus_data_t'(rec.data) : '0;
    @(posedge clk);
    @(negedge clk);
    waited = 1;
    while (!ack) begin
      if (waited >= ack_limit) begin
        stop_with_error($sformatf("no acknowledge within %0d cycles for address 0x%0h",
                                  ack_limit, rec.addr));
      end
      @(negedge clk);
      waited++;
    end
    check_value("ack_o latency", waited, 32'd2);
    if (!write) begin
      check_value("dat_o", dat_r, rec.data);
    end
    @(posedge clk);
    #drive_delay;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    @(negedge clk);
    check_value("ack_o after one cycle", {31'd0, ack}, 32'd0);
    idle = $unsigned($random(seed)) % 4;
    repeat (idle) @(posedge clk);
  endtask

  task automatic observe(input record_t rec);
    int weight;
    int value;
    bit allowed;
    bit seen_a;
    bit seen_b;
    weight = 1;
    if (rec.weight == 1) begin
      weight = `APU_PULSE_WEIGHT;
    end else if (rec.weight == 2) begin
      weight = `APU_TND_WEIGHT;
    end
    seen_a = 1'b0;
    seen_b = 1'b0;
    repeat (rec.settle) @(negedge clk);
    for (int c = 0; c < rec.len; c++) begin
      @(negedge clk);
      value = int'(audio);
      allowed = 1'b0;
      for (int k = 0; k < rec.count; k++) begin
        if (value == (rec.lo + k * rec.step) * weight) begin
          allowed = 1'b1;
        end
      end
      if (!allowed) begin
        stop_with_error($sformatf(
          "Mismatch at %0t: audio_o is %0d, expected (%0d + k * %0d) * %0d with k < %0d",
          $time, value, rec.lo, rec.step, weight, rec.count));
      end
      seen_a |= (value == rec.req_a * weight);
      seen_b |= (value == rec.req_b * weight);
    end
    if (!seen_a || !seen_b) begin
      stop_with_error($sformatf("audio_o never showed both %0d and %0d in the window ending at %0t",
                                rec.req_a * weight, rec.req_b * weight, $time));
    end
  endtask

  initial begin
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    sel = '0;
    dat_w = '0;
    load_records();
    wait (rst === 1'b0);
    foreach (records[i]) begin
      case (records[i].kind)
        "W": bus_access(1'b1, records[i]);
        "R": bus_access(1'b0, records[i]);
        default: observe(records[i]);
      endcase
    end
    $display("Finished with no errors");
    $finish;
  end

  // watchdog sized from the record lengths
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    stop_with_error($sformatf("watchdog expired after %0d cycles", budget_cycles));
  end

endmodule

/* testbench/apu_stimulus.txt */
# W addr sel data | R addr sel expected  (hex, addr is the word address)
# O settle len weight lo step count req_a req_b  (decimal, weight 0 none 1 pulse 2 tnd)
O 0 64 0 0 0 1 0 0
W 0000 2 a5a5a53c
W 0001 2 000000a7
W 0003 2 1234565e
W 0005 1 000000ff
W 0004 8 00000096
W 0002 f 00000011
R 0000 2 0000003c
R 0001 2 000000a7
R 0003 2 0000005e
R 0005 1 000000ff
R 0004 8 00000096
R 0002 1 00000011
W 0800 2 00000077
W 1001 2 00000011
W 1805 1 00000000
R 0800 2 00000000
R 1000 1 00000000
R 1805 1 00000000
R 0000 2 0000003c
R 0001 2 000000a7
R 0005 1 000000ff
W 0000 1 00000085
W 0000 4 00000002
W 0000 8 00000000
W 0005 2 00000001
R 0005 2 00000001
O 0 200 1 0 5 2 0 5
W 0005 2 00000000
O 8 64 0 0 0 1 0 0
W 0003 1 00000006
W 0003 4 00000000
W 0005 2 00000008
O 0 400 2 0 12 2 0 12
W 0005 2 00000000
O 8 64 0 0 0 1 0 0
W 0003 4 00000080
W 0005 2 00000008
O 0 400 2 0 12 2 0 12
W 0005 2 00000000
O 8 64 0 0 0 1 0 0
W 0002 4 00000001
W 0002 8 00000000
W 0005 2 00000004
O 0 300 2 0 3 16 0 45

/* list.f */
+incdir+include
verilog/apu_bus_pkg.sv
verilog/apu_audio_pkg.sv
verilog/apu_bus_ctrl.sv
verilog/apu_pulse.sv
verilog/apu_noise.sv
verilog/apu_triangle.sv
verilog/apu_mixer.sv
verilog/apu_top.sv
testbench/tb_clock.sv
testbench/apu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the apu testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module apu_tb --Mdir "$build_dir" -o apu_sim -f list.f; then
  echo "compile step failed"
  exit 1
fi

"$build_dir/apu_sim" > "$log_file" 2>&1
run_status=$?

if ! cat "$log_file"; then
  echo "could not read $log_file"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -qx "Finished with no errors" "$log_file"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
